/* block_memory.sv */
`include "cache_defines.svh"

module block_memory (
	input  logic                             clk_i,
	input  logic                             arst_n_i,
	input  logic                             mem_req_i,
	input  mem_pkg::mem_op_e                 mem_op_i,
	input  logic [`ADDR_W-1:0]               mem_addr_i,
	input  logic [`L1_BLOCK_BYTES*8-1:0]     mem_wdata_i,
	output logic                             mem_ack_o,
	output logic [`L1_BLOCK_BYTES*8-1:0]     mem_rdata_o
);
	localparam int BLK_W = `L1_BLOCK_BYTES * 8;
	localparam int IDX_W = $clog2(`MEM_BLOCKS);
	localparam int CNT_W = $clog2(`MEM_LATENCY + 1);
	localparam logic [7:0] FILL_KEY = 8'h5A; // xor key of the reset pattern

	logic [BLK_W-1:0] mem_arr [`MEM_BLOCKS];
	logic [CNT_W-1:0] cnt_q; // cycles spent on the pending request
	logic [IDX_W-1:0] idx;
	logic             fire;  // last wait cycle, ack follows

	// block address modulo MEM_BLOCKS
	assign idx = mem_addr_i[`L1_OFF_W +: IDX_W];

	// no new transaction in the ack cycle itself
	assign fire = mem_req_i && !mem_ack_o && (cnt_q == CNT_W'(`MEM_LATENCY - 1));

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt_q     <= '0;
			mem_ack_o <= 1'b0;
			// byte i of block b = (b*16 + i) ^ 0x5a
			for (int b = 0; b < `MEM_BLOCKS; b++) begin
				for (int i = 0; i < `L1_BLOCK_BYTES; i++) begin
					mem_arr[b][i*8 +: 8] <= 8'(b * `L1_BLOCK_BYTES + i) ^ FILL_KEY;
				end
			end
		end else begin
			mem_ack_o <= fire; // single cycle pulse
			if (fire || mem_ack_o || !mem_req_i) begin
				cnt_q <= '0;
			end else begin
				cnt_q <= cnt_q + 1'b1;
			end
			if (fire && mem_op_i == mem_pkg::mem_write) begin
				mem_arr[idx] <= mem_wdata_i; // visible together with the ack
			end
		end
	end

	// read data register, valid while mem_ack_o is high
	always_ff @(posedge clk_i) begin
		if (fire && mem_op_i == mem_pkg::mem_read) begin
			mem_rdata_o <= mem_arr[idx];
		end
	end

endmodule

/* cache_defines.svh */
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// cpu side byte address width
`define ADDR_W 32

// l1 geometry, 4 ways x 8 sets x 16 byte blocks
`define L1_WAYS 4
`define L1_SETS 8
`define L1_BLOCK_BYTES 16

// address split is tag | set | offset
`define L1_OFF_W 4
`define L1_SET_W 3
`define L1_TAG_W 25

// backing store size in blocks and its fixed ack latency in cycles
`define MEM_BLOCKS 64
`define MEM_LATENCY 3

`endif

/* cache_pkg.sv */
package cache_pkg;

	// l1 controller states
	typedef enum logic [1:0] {
		st_comp_tag,      // idle, compares tag of incoming request
		st_allocate,      // block fetch on a miss
		st_write_through, // merged line goes out to memory
		st_output         // ready pulse to the cpu
	} cache_state_e;

endpackage

/* l1_data_cache.sv */
`include "cache_defines.svh"

module l1_data_cache (
	input  logic                             clk_i,
	input  logic                             arst_n_i,
	// cpu side
	input  logic                             cpu_valid_i,
	input  mem_pkg::cpu_op_e                 cpu_op_i,
	input  logic [`ADDR_W-1:0]               cpu_addr_i,
	input  logic [7:0]                       cpu_wdata_i,
	output logic                             cpu_ready_o,
	output logic [7:0]                       cpu_rdata_o,
	// block bus towards backing memory
	output logic                             mem_req_o,
	output mem_pkg::mem_op_e                 mem_op_o,
	output logic [`ADDR_W-1:0]               mem_addr_o,
	output logic [`L1_BLOCK_BYTES*8-1:0]     mem_wdata_o,
	input  logic                             mem_ack_i,
	input  logic [`L1_BLOCK_BYTES*8-1:0]     mem_rdata_i
);
	localparam int BLK_W = `L1_BLOCK_BYTES * 8;
	localparam int WAY_W = $clog2(`L1_WAYS);

	// request fields, cpu holds them stable until ready
	logic [`L1_TAG_W-1:0] tag;
	logic [`L1_SET_W-1:0] set;
	logic [`L1_OFF_W-1:0] off;

	// storage, indexed [way][set]
	logic [`L1_TAG_W-1:0] tag_arr  [`L1_WAYS][`L1_SETS];
	logic [BLK_W-1:0]     data_arr [`L1_WAYS][`L1_SETS];
	logic [`L1_WAYS-1:0]  valid_q  [`L1_SETS]; // one bit per way

	cache_pkg::cache_state_e state_q;
	cache_pkg::cache_state_e state_d;

	logic [WAY_W-1:0] way_q;   // way in use for the current request
	logic [WAY_W-1:0] way_sel; // way chosen this cycle
	logic [WAY_W-1:0] hit_way;
	logic [WAY_W-1:0] victim;  // lru pick for the addressed set
	logic             hit;
	logic             is_store;
	logic             touch;

	logic [BLK_W-1:0] line;   // currently selected line
	logic [BLK_W-1:0] merged; // line with the store byte patched in

	// address format tag[31:7] set[6:4] off[3:0]
	assign tag = cpu_addr_i[`ADDR_W-1 -: `L1_TAG_W];
	assign set = cpu_addr_i[`L1_OFF_W +: `L1_SET_W];
	assign off = cpu_addr_i[`L1_OFF_W-1:0];

	assign is_store = (cpu_op_i == mem_pkg::op_store);

	// parallel tag compare over all ways of the set
	always_comb begin
		hit     = 1'b0;
		hit_way = '0;
		for (int w = 0; w < `L1_WAYS; w++) begin
			if (valid_q[set][w] && (tag_arr[w][set] == tag)) begin
				hit     = 1'b1;
				hit_way = WAY_W'(w);
			end
		end
	end

	// hit uses the matching way, miss takes the lru victim
	always_comb begin
		if (state_q == cache_pkg::st_comp_tag) begin
			way_sel = hit ? hit_way : victim;
		end else begin
			way_sel = way_q; // held for the rest of the request
		end
	end

	assign line = data_arr[way_q][set];

	// byte merge for stores
	always_comb begin
		merged = line;
		merged[{off, 3'b000} +: 8] = cpu_wdata_i;
	end

	// next state
	always_comb begin
		state_d = state_q;
		case (state_q)
			cache_pkg::st_comp_tag: begin
				if (cpu_valid_i) begin // request accepted here
					if (!hit) begin
						state_d = cache_pkg::st_allocate;
					end else if (is_store) begin
						state_d = cache_pkg::st_write_through;
					end else begin
						state_d = cache_pkg::st_output; // load hit, ready next cycle
					end
				end
			end
			cache_pkg::st_allocate: begin
				if (mem_ack_i) begin // block arrived
					state_d = is_store ? cache_pkg::st_write_through : cache_pkg::st_output;
				end
			end
			cache_pkg::st_write_through: begin
				if (mem_ack_i) begin
					state_d = cache_pkg::st_output;
				end
			end
			cache_pkg::st_output: begin
				state_d = cache_pkg::st_comp_tag;
			end
			default: begin
				state_d = cache_pkg::st_comp_tag;
			end
		endcase
	end

	// control state and valid bits
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= cache_pkg::st_comp_tag;
			way_q   <= '0;
			for (int s = 0; s < `L1_SETS; s++) begin
				valid_q[s] <= '0; // cold cache
			end
		end else begin
			state_q <= state_d;
			way_q   <= way_sel;
			if (state_q == cache_pkg::st_allocate && mem_ack_i) begin
				valid_q[set][way_q] <= 1'b1;
			end
		end
	end

	// tag and data arrays
	always_ff @(posedge clk_i) begin
		if (state_q == cache_pkg::st_allocate && mem_ack_i) begin
			tag_arr[way_q][set]  <= tag;
			data_arr[way_q][set] <= mem_rdata_i; // fill from memory
		end else if (state_q == cache_pkg::st_write_through && mem_ack_i) begin
			data_arr[way_q][set] <= merged; // memory now holds the same line
		end
	end

	// recency update on the edge into st_output
	assign touch = (state_d == cache_pkg::st_output);

	l1_lru u_lru (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.set_i    (set),
		.touch_i  (touch),
		.way_i    (way_sel),
		.victim_o (victim)
	);

	// cpu outputs
	assign cpu_ready_o = (state_q == cache_pkg::st_output); // one cycle pulse
	assign cpu_rdata_o = line[{off, 3'b000} +: 8];           // byte select

	// memory bus, request held until ack
	assign mem_req_o = (state_q == cache_pkg::st_allocate) ||
	                   (state_q == cache_pkg::st_write_through);
	assign mem_op_o = (state_q == cache_pkg::st_write_through) ? mem_pkg::mem_write
	                                                           : mem_pkg::mem_read;
	assign mem_addr_o  = {tag, set, {`L1_OFF_W{1'b0}}}; // block aligned
	assign mem_wdata_o = merged; // whole line written through

endmodule

/* l1_lru.sv */
`include "cache_defines.svh"

module l1_lru (
	input  logic                             clk_i,
	input  logic                             arst_n_i,
	input  logic [`L1_SET_W-1:0]             set_i,
	input  logic                             touch_i,
	input  logic [$clog2(`L1_WAYS)-1:0]      way_i,
	output logic [$clog2(`L1_WAYS)-1:0]      victim_o
);
	localparam int WAY_W = $clog2(`L1_WAYS);

	// order_q[s][0] is the newest way of set s, last entry the oldest
	logic [WAY_W-1:0] order_q [`L1_SETS][`L1_WAYS];
	logic [WAY_W-1:0] pos; // where way_i currently sits in the order

	// locate the touched way in its set
	always_comb begin
		pos = '0;
		for (int i = 0; i < `L1_WAYS; i++) begin
			if (order_q[set_i][i] == way_i) begin
				pos = WAY_W'(i);
			end
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			// way 0 newest ... way 3 oldest in every set
			for (int s = 0; s < `L1_SETS; s++) begin
				for (int i = 0; i < `L1_WAYS; i++) begin
					order_q[s][i] <= WAY_W'(i);
				end
			end
		end else if (touch_i) begin
			// entries ahead of the touched way slide back one slot
			for (int i = 1; i < `L1_WAYS; i++) begin
				if (WAY_W'(i) <= pos) begin
					order_q[set_i][i] <= order_q[set_i][i-1];
				end
			end
			order_q[set_i][0] <= way_i; // touched way becomes newest
		end
	end

	assign victim_o = order_q[set_i][`L1_WAYS-1]; // oldest of the addressed set

endmodule

/* mem_pkg.sv */
package mem_pkg;

	// cpu access kind, byte granular only
	typedef enum logic {
		op_load,
		op_store
	} cpu_op_e;

	// block bus access kind between l1 and backing memory
	typedef enum logic {mem_read, mem_write} mem_op_e;

endpackage

/* mem_subsystem_top.sv */
`include "cache_defines.svh"

module mem_subsystem_top (
	input  logic                  clk_i,
	input  logic                  arst_n_i,
	input  logic                  cpu_valid_i,
	input  mem_pkg::cpu_op_e      cpu_op_i,
	input  logic [`ADDR_W-1:0]    cpu_addr_i,
	input  logic [7:0]            cpu_wdata_i,
	output logic                  cpu_ready_o,
	output logic [7:0]            cpu_rdata_o
);
	// l1 <-> backing memory block bus
	logic                          mem_req;
	mem_pkg::mem_op_e              mem_op;
	logic [`ADDR_W-1:0]            mem_addr;
	logic [`L1_BLOCK_BYTES*8-1:0]  mem_wdata;
	logic                          mem_ack;
	logic [`L1_BLOCK_BYTES*8-1:0]  mem_rdata;

	l1_data_cache u_l1d (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.cpu_valid_i (cpu_valid_i),
		.cpu_op_i    (cpu_op_i),
		.cpu_addr_i  (cpu_addr_i),
		.cpu_wdata_i (cpu_wdata_i),
		.cpu_ready_o (cpu_ready_o),
		.cpu_rdata_o (cpu_rdata_o),
		.mem_req_o   (mem_req),
		.mem_op_o    (mem_op),
		.mem_addr_o  (mem_addr),
		.mem_wdata_o (mem_wdata),
		.mem_ack_i   (mem_ack),
		.mem_rdata_i (mem_rdata)
	);

	// stands in for l2
	block_memory u_mem (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.mem_req_i   (mem_req),
		.mem_op_i    (mem_op),
		.mem_addr_i  (mem_addr),
		.mem_wdata_i (mem_wdata),
		.mem_ack_o   (mem_ack),
		.mem_rdata_o (mem_rdata)
	);

endmodule

/* run.sh */
#!/bin/sh
# build with verilator, run, then judge the run from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_mem_subsystem -f tb.f \
	-o tb_sim > sim.log 2>&1 && ./obj_dir/tb_sim >> sim.log 2>&1
grep -q "^STATUS: PASS$" sim.log && echo "simulation passed" && exit 0 ||
	{ echo "simulation failed, see sim.log"; exit 1; }

/* tb.f */
+incdir+.
mem_pkg.sv
cache_pkg.sv
l1_lru.sv
l1_data_cache.sv
block_memory.sv
mem_subsystem_top.sv
tb_mem_subsystem.sv

/* tb_mem_subsystem.sv */
`include "cache_defines.svh"

module tb_mem_subsystem;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 5;
	localparam int SPAN         = `MEM_BLOCKS * `L1_BLOCK_BYTES; // bytes behind the cache
	localparam int SPAN_W       = $clog2(SPAN);
	localparam logic [7:0] FILL_KEY = 8'h5A;

	logic                 clk;
	logic                 arst_n;
	logic                 cpu_valid;
	mem_pkg::cpu_op_e     cpu_op;
	logic [`ADDR_W-1:0]   cpu_addr;
	logic [7:0]           cpu_wdata;
	logic                 cpu_ready;
	logic [7:0]           cpu_rdata;

	// stimulus table with one entry per request
	string                names  [$];
	mem_pkg::cpu_op_e     ops    [$];
	logic [`ADDR_W-1:0]   addrs  [$];
	logic [7:0]           wdatas [$];
	bit                   hits   [$]; // hit expected
	logic [7:0]           exps   [$]; // expected read byte

	logic [7:0] shadow [SPAN]; // what memory and cache should hold
	int         seed = 85;
	bit         table_built;
	int         cur;              // entry in flight
	int         lat;              // cycles from acceptance to ready
	logic [7:0] got;
	bit         hit_seen;
	int         val_errs;
	int         time_errs;

	mem_subsystem_top uut (
		.clk_i       (clk),
		.arst_n_i    (arst_n),
		.cpu_valid_i (cpu_valid),
		.cpu_op_i    (cpu_op),
		.cpu_addr_i  (cpu_addr),
		.cpu_wdata_i (cpu_wdata),
		.cpu_ready_o (cpu_ready),
		.cpu_rdata_o (cpu_rdata)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// reset contents of the byte at addr
	function automatic logic [7:0] fill_byte(input int addr);
		int blk;
		int idx;
		blk = addr / `L1_BLOCK_BYTES;
		idx = addr % `L1_BLOCK_BYTES;
		return 8'(blk * `L1_BLOCK_BYTES + idx) ^ FILL_KEY;
	endfunction

	// append one request
	// stores draw a random byte and update the shadow
	function automatic void add_row(input string name, input mem_pkg::cpu_op_e op,
	                                input logic [`ADDR_W-1:0] addr, input bit hit);
		logic [7:0] wdata;
		wdata = 8'h00;
		if (op == mem_pkg::op_store) begin
			wdata = 8'($random(seed));
			if (wdata == shadow[addr[SPAN_W-1:0]]) begin
				wdata = ~wdata; // a store always changes the byte it lands on
			end
			shadow[addr[SPAN_W-1:0]] = wdata; // write-through keeps memory in step
		end
		names.push_back(name);
		ops.push_back(op);
		addrs.push_back(addr);
		wdatas.push_back(wdata);
		hits.push_back(hit);
		exps.push_back(shadow[addr[SPAN_W-1:0]]); // stores echo the new byte
	endfunction

	task automatic build_table();
		for (int a = 0; a < SPAN; a++) begin
			shadow[a] = fill_byte(a);
		end
		add_row("cold_load",        mem_pkg::op_load,  32'h010, 1'b0); // set 1
		add_row("same_block_load",  mem_pkg::op_load,  32'h01B, 1'b1);
		add_row("store_hit",        mem_pkg::op_store, 32'h015, 1'b1);
		add_row("load_after_store", mem_pkg::op_load,  32'h015, 1'b1);
		add_row("store_alloc",      mem_pkg::op_store, 32'h0A7, 1'b0); // set 2 block not cached
		add_row("load_alloc",       mem_pkg::op_load,  32'h0A7, 1'b1);
		// tags 0 to 4 in set 3
		add_row("set3_t0",          mem_pkg::op_load,  32'h030, 1'b0);
		add_row("set3_t1",          mem_pkg::op_load,  32'h0B4, 1'b0);
		add_row("set3_t2",          mem_pkg::op_load,  32'h138, 1'b0);
		add_row("set3_t3",          mem_pkg::op_load,  32'h1B2, 1'b0);
		add_row("set3_t0_again",    mem_pkg::op_load,  32'h03C, 1'b1); // t1 now oldest
		add_row("set3_t4",          mem_pkg::op_load,  32'h235, 1'b0); // evicts t1
		add_row("set3_t1_reload",   mem_pkg::op_load,  32'h0B4, 1'b0);
		add_row("set3_t0_reload",   mem_pkg::op_load,  32'h030, 1'b1);
		// stored block in set 5 pushed out by four other tags
		add_row("wt_store",         mem_pkg::op_store, 32'h05E, 1'b0);
		add_row("wt_fill_t1",       mem_pkg::op_load,  32'h0D0, 1'b0);
		add_row("wt_fill_t2",       mem_pkg::op_load,  32'h150, 1'b0);
		add_row("wt_fill_t3",       mem_pkg::op_load,  32'h1D0, 1'b0);
		add_row("wt_fill_t4",       mem_pkg::op_load,  32'h250, 1'b0);
		add_row("wt_reload",        mem_pkg::op_load,  32'h05E, 1'b0); // byte comes from memory
		// one load per set
		add_row("sweep_s0",         mem_pkg::op_load,  32'h30F, 1'b0);
		add_row("sweep_s1",         mem_pkg::op_load,  32'h015, 1'b1);
		add_row("sweep_s2",         mem_pkg::op_load,  32'h0A7, 1'b1);
		add_row("sweep_s3",         mem_pkg::op_load,  32'h030, 1'b1);
		add_row("sweep_s4",         mem_pkg::op_load,  32'h344, 1'b0);
		add_row("sweep_s5",         mem_pkg::op_load,  32'h05E, 1'b1);
		add_row("sweep_s6",         mem_pkg::op_load,  32'h36A, 1'b0);
		add_row("sweep_s7",         mem_pkg::op_load,  32'h371, 1'b0);
	endtask

	// one cpu request held until ready is seen
	task automatic run_request(input int n);
		@(posedge clk);
		cpu_valid <= 1'b1;
		cpu_op    <= ops[n];
		cpu_addr  <= addrs[n];
		cpu_wdata <= wdatas[n];
		@(posedge clk); // acceptance edge with the controller idle in tag compare
		@(negedge clk);
		lat = 1;
		while (!cpu_ready) begin
			@(negedge clk);
			lat++;
		end
		got = cpu_rdata; // stable mid-cycle
		@(posedge clk);
		cpu_valid <= 1'b0; // same edge that sees ready
	endtask

	initial begin
		clk       = 1'b0;
		arst_n    = 1'b0;
		cpu_valid = 1'b0;
		cpu_op    = mem_pkg::op_load;
		cpu_addr  = '0;
		cpu_wdata = 8'h00;
		val_errs  = 0;
		time_errs = 0;
		cur       = 0;
		build_table();
		table_built = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
		for (int n = 0; n < names.size(); n++) begin
			cur = n;
			run_request(n);
			assert (got == exps[n]) else begin
				$display("ERR %s expected %02h actual %02h", names[n], exps[n], got);
				val_errs++;
			end
			// a load hit is ready one cycle after acceptance
			// a store hit needs one block transaction plus the output cycle
			if (ops[n] == mem_pkg::op_load) begin
				hit_seen = (lat == 1);
			end else begin
				hit_seen = (lat <= `MEM_LATENCY + 2);
			end
			assert (hit_seen == hits[n]) else begin
				$display("%s was expected to %s, but ready came %0d cycles after acceptance",
				         names[n], hits[n] ? "hit" : "miss", lat);
				time_errs++;
			end
		end
		$display("value errors: %0d, timing errors: %0d", val_errs, time_errs);
		if (val_errs == 0 && time_errs == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	// worst case per entry is a store miss with two block transactions
	initial begin
		wait (table_built);
		#((names.size() * (2 * `MEM_LATENCY + 6) + RESET_CYCLES) * CLK_PERIOD);
		$display("timeout while waiting for the cache to answer entry %0d", cur);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule
